//--- verif/mem_subsys_testdata.txt
// op size is_signed addr wdata exp_rdata exp_err, all hex
// op 0 load, 1 store, 2 load with an ignored word store pulsed while busy; exp_rdata unused on stores
1 2 0 00000000 12345678 00000000 0
0 2 0 00000000 00000000 12345678 0
1 2 0 000003fc cafef00d 00000000 0
0 2 0 000003fc 00000000 cafef00d 0
1 2 0 00000010 11111111 00000000 0
1 0 0 00000010 0000007a 00000000 0
1 1 0 00000012 dead9c3e 00000000 0
0 2 0 00000010 00000000 9c3e117a 0
1 0 0 00000023 12345681 00000000 0
1 1 0 00000020 0000f00f 00000000 0
1 0 0 00000022 00000042 00000000 0
0 2 0 00000020 00000000 8142f00f 0
1 2 0 00000030 80f27f01 00000000 0
0 0 1 00000030 00000000 00000001 0
0 0 1 00000031 00000000 0000007f 0
0 0 1 00000032 00000000 fffffff2 0
0 0 1 00000033 00000000 ffffff80 0
0 0 0 00000030 00000000 00000001 0
0 0 0 00000031 00000000 0000007f 0
0 0 0 00000032 00000000 000000f2 0
0 0 0 00000033 00000000 00000080 0
0 1 1 00000030 00000000 00007f01 0
0 1 1 00000032 00000000 ffff80f2 0
0 1 0 00000030 00000000 00007f01 0
0 1 0 00000032 00000000 000080f2 0
0 1 1 00000012 00000000 ffff9c3e 0
1 2 0 00000400 deadbeef 00000000 1
0 2 0 00000400 00000000 00000000 1
1 0 0 000007fd 00000055 00000000 1
0 1 1 fffffff0 00000000 00000000 1
0 2 0 00000000 00000000 12345678 0
0 2 0 000003fc 00000000 cafef00d 0
1 1 0 00000041 00001234 00000000 1
0 1 0 00000043 00000000 00000000 1
0 2 0 00000002 00000000 00000000 1
1 2 0 00000013 ffffffff 00000000 1
0 2 0 00000010 00000000 9c3e117a 0
0 2 0 00000040 00000000 00000000 0
2 2 0 00000000 a5a5a5a5 12345678 0
0 2 0 00000000 00000000 12345678 0
2 2 0 000003fc 00000000 cafef00d 0
0 2 0 000003fc 00000000 cafef00d 0

//--- mem_subsys_top.f
src/lsu_pkg.sv
src/lsu_lane_align.sv
src/lsu_axi_master.sv
src/axil_sram.sv
src/mem_subsys_top.sv
verif/mem_subsys_checker.sv
verif/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mem_subsys_tb \
	-f mem_subsys_top.f --Mdir obj_dir -o mem_subsys_sim

out=$(./obj_dir/mem_subsys_sim)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

//--- verif/mem_subsys_tb.sv
module mem_subsys_tb;
	import lsu_pkg::*;

	localparam int          MAX_TESTS = 64;
	localparam int          FIELDS    = 7;              // Words per access in the data file
	localparam logic [31:0] SEED      = 32'h64cf_d4be;
	localparam string       DATA_FILE = "verif/mem_subsys_testdata.txt";

	logic              CLK;
	logic              NRST;
	logic              load_req;
	logic              store_req;
	logic [1:0]        size;
	logic              is_signed;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              busy;
	logic              done;
	logic [DATA_W-1:0] rdata;
	logic              err;

	logic [31:0] td [MAX_TESTS*FIELDS];   // Flat copy of the data file
	logic [31:0] rng;
	int          n_tests;
	int          total_fail;
	bit          tests_loaded = 1'b0;

	always #2 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ==============================
	// One access from the data file
	// ==============================
	task automatic issue_access(input int idx);
		logic [31:0] op;
		int          base;
		base = idx * FIELDS;
		op   = td[base];
		do
			@(negedge CLK);
		while (busy);
		rng = xorshift32(rng);
		repeat (rng[1:0]) @(posedge CLK);       // Random gap of 0 to 3 cycles
		@(posedge CLK);
		load_req  <= (op != 32'd1);
		store_req <= (op == 32'd1);
		size      <= td[base+1][1:0];
		is_signed <= td[base+2][0];
		addr      <= td[base+3];
		wdata     <= td[base+4];
		u_scoreboard.expect_result(idx + 1, op != 32'd1, td[base+5], td[base+6][0]);
		@(posedge CLK);
		load_req  <= 1'b0;
		store_req <= 1'b0;
		if (op == 32'd2)
		begin
			// Word store pulsed while the load is in flight
			store_req <= 1'b1;
			size      <= SIZE_WORD;
			@(posedge CLK);
			store_req <= 1'b0;
		end
	endtask

	initial
	begin
		CLK       = 1'b0;
		NRST      = 1'b0;
		load_req  = 1'b0;
		store_req = 1'b0;
		size      = SIZE_BYTE;
		is_signed = 1'b0;
		addr      = '0;
		wdata     = '0;
		rng       = SEED;
		for (int i = 0; i < MAX_TESTS*FIELDS; i++)
			td[i] = 32'hffff_0000 | i;           // Op field above 2 marks the end
		$readmemh(DATA_FILE, td);
		n_tests = 0;
		while ((n_tests < MAX_TESTS) && (td[n_tests*FIELDS] <= 32'd2))
			n_tests++;
		tests_loaded = 1'b1;

		repeat (5) @(posedge CLK);
		NRST <= 1'b1;
		repeat (MEM_WORDS + 5) @(posedge CLK);  // SRAM clear
		for (int i = 0; i < n_tests; i++)
			issue_access(i);
		do
			@(negedge CLK);
		while (busy);
		repeat (2) @(negedge CLK);

		if (n_tests == 0)
			$display("No accesses could be read from %s", DATA_FILE);
		u_scoreboard.final_report(n_tests, total_fail);
		if ((total_fail == 0) && (n_tests > 0))
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (tests_loaded);
		repeat (n_tests * 20 + MEM_WORDS + 50) @(posedge CLK);
		$display("Timeout: the run did not finish in %0d cycles",
			n_tests * 20 + MEM_WORDS + 50);
		$display("Checks failed");
		$finish;
	end

	mem_subsys_top UUT (
		.CLK       (CLK),
		.NRST      (NRST),
		.load_req  (load_req),
		.store_req (store_req),
		.size      (size),
		.is_signed (is_signed),
		.addr      (addr),
		.wdata     (wdata),
		.busy      (busy),
		.done      (done),
		.rdata     (rdata),
		.err       (err)
	);

	mem_subsys_checker u_scoreboard (
		.CLK   (CLK),
		.NRST  (NRST),
		.busy  (busy),
		.done  (done),
		.rdata (rdata),
		.err   (err)
	);

endmodule

//--- verif/mem_subsys_checker.sv
module mem_subsys_checker (
	input  logic                       CLK,
	input  logic                       NRST,
	input  logic                       busy,
	input  logic                       done,
	input  logic [lsu_pkg::DATA_W-1:0] rdata,
	input  logic                       err
);
	import lsu_pkg::*;

	// Outstanding requests, oldest first
	int                exp_id    [$];
	logic              exp_load  [$];
	logic [DATA_W-1:0] exp_rdata [$];
	logic              exp_err   [$];

	int                pass_count = 0;
	int                fail_count = 0;
	logic              stray_busy = 1'b0;    // Already reported this busy episode
	logic [DATA_W-1:0] last_rdata;           // Result of the latest load
	bit                have_load  = 1'b0;

	task automatic expect_result(input int id, input logic is_load,
		input logic [DATA_W-1:0] rd, input logic e);
		exp_id.push_back(id);
		exp_load.push_back(is_load);
		exp_rdata.push_back(rd);
		exp_err.push_back(e);
	endtask

	// ==============================
	// Compare on each done pulse
	// ==============================
	task automatic check_done();
		int                id;
		logic              is_load;
		logic [DATA_W-1:0] rd;
		logic              e;
		int                errs;
		if (exp_id.size() == 0)
		begin
			$display("Error at time %0t: done pulsed with no request pending", $time);
			fail_count++;
		end
		else
		begin
			id      = exp_id.pop_front();
			is_load = exp_load.pop_front();
			rd      = exp_rdata.pop_front();
			e       = exp_err.pop_front();
			errs    = 0;
			if (err !== e)
			begin
				$display("Mismatch at time %0t: err got %b expected %b", $time, err, e);
				errs++;
			end
			if (is_load)
			begin
				if (rdata !== rd)
				begin
					$display("Mismatch at time %0t: rdata got %h expected %h",
						$time, rdata, rd);
					errs++;
				end
				last_rdata = rd;
				have_load  = 1'b1;
			end
			else if (have_load && (rdata !== last_rdata))  // Stores leave rdata alone
			begin
				$display("Mismatch at time %0t: rdata got %h expected %h",
					$time, rdata, last_rdata);
				errs++;
			end
			if (errs == 0)
			begin
				pass_count++;
				$display("Test %0d ok", id);
			end
			else
			begin
				fail_count++;
				$display("Test %0d FAILED", id);
			end
		end
	endtask

	always @(negedge CLK)
	begin
		if (NRST)
		begin
			if (done)
				check_done();
			if (busy && (exp_id.size() == 0) && !stray_busy)
			begin
				$display("Error at time %0t: busy is high with no request pending", $time);
				fail_count++;
			end
			stray_busy = busy && (exp_id.size() == 0);
		end
	end

	task automatic final_report(input int n_tests, output int total_fail);
		total_fail = fail_count + exp_id.size();
		if (exp_id.size() != 0)
			$display("Error: %0d requests never signalled done", exp_id.size());
		$display("Summary: %0d tests, %0d passed, %0d failures",
			n_tests, pass_count, total_fail);
	endtask

endmodule

//--- src/mem_subsys_top.sv
module mem_subsys_top (
	input  logic                       CLK,
	input  logic                       NRST,
	input  logic                       load_req,
	input  logic                       store_req,
	input  logic [1:0]                 size,
	input  logic                       is_signed,
	input  logic [lsu_pkg::ADDR_W-1:0] addr,
	input  logic [lsu_pkg::DATA_W-1:0] wdata,
	output logic                       busy,
	output logic                       done,
	output logic [lsu_pkg::DATA_W-1:0] rdata,
	output logic                       err
);
	import lsu_pkg::*;

	// ==============================
	// AXI4-Lite link
	// ==============================
	logic [ADDR_W-1:0] axi_awaddr;
	logic              axi_awvalid;
	logic              axi_awready;
	logic [DATA_W-1:0] axi_wdata;
	logic [STRB_W-1:0] axi_wstrb;
	logic              axi_wvalid;
	logic              axi_wready;
	logic [1:0]        axi_bresp;
	logic              axi_bvalid;
	logic              axi_bready;
	logic [ADDR_W-1:0] axi_araddr;
	logic              axi_arvalid;
	logic              axi_arready;
	logic [DATA_W-1:0] axi_rdata;
	logic [1:0]        axi_rresp;
	logic              axi_rvalid;
	logic              axi_rready;

	lsu_axi_master u_lsu (
		.CLK       (CLK),
		.NRST      (NRST),
		.load_req  (load_req),
		.store_req (store_req),
		.size      (size),
		.is_signed (is_signed),
		.addr      (addr),
		.wdata     (wdata),
		.busy      (busy),
		.done      (done),
		.err       (err),
		.rdata     (rdata),
		.awaddr    (axi_awaddr),
		.awvalid   (axi_awvalid),
		.awready   (axi_awready),
		.wdata_o   (axi_wdata),
		.wstrb     (axi_wstrb),
		.wvalid    (axi_wvalid),
		.wready    (axi_wready),
		.bresp     (axi_bresp),
		.bvalid    (axi_bvalid),
		.bready    (axi_bready),
		.araddr    (axi_araddr),
		.arvalid   (axi_arvalid),
		.arready   (axi_arready),
		.rdata_i   (axi_rdata),
		.rresp     (axi_rresp),
		.rvalid    (axi_rvalid),
		.rready    (axi_rready)
	);

	axil_sram u_sram (
		.CLK     (CLK),
		.NRST    (NRST),
		.awaddr  (axi_awaddr),
		.awvalid (axi_awvalid),
		.awready (axi_awready),
		.wdata   (axi_wdata),
		.wstrb   (axi_wstrb),
		.wvalid  (axi_wvalid),
		.wready  (axi_wready),
		.bresp   (axi_bresp),
		.bvalid  (axi_bvalid),
		.bready  (axi_bready),
		.araddr  (axi_araddr),
		.arvalid (axi_arvalid),
		.arready (axi_arready),
		.rdata   (axi_rdata),
		.rresp   (axi_rresp),
		.rvalid  (axi_rvalid),
		.rready  (axi_rready)
	);

endmodule

//--- src/axil_sram.sv
module axil_sram (
	input  logic                       CLK,
	input  logic                       NRST,
	// Write address and data
	input  logic [lsu_pkg::ADDR_W-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [lsu_pkg::DATA_W-1:0] wdata,
	input  logic [lsu_pkg::STRB_W-1:0] wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	// Write response
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	// Read address
	input  logic [lsu_pkg::ADDR_W-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	// Read data
	output logic [lsu_pkg::DATA_W-1:0] rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready
);
	import lsu_pkg::*;

	logic [DATA_W-1:0]    mem [MEM_WORDS];
	logic                 init_active;      // Clearing the array after reset
	logic [MEM_IDX_W-1:0] init_cnt;
	logic                 wr_hs;
	logic                 rd_hs;
	logic                 aw_in_range;
	logic                 ar_in_range;
	logic [MEM_IDX_W-1:0] aw_idx;
	logic [MEM_IDX_W-1:0] ar_idx;

	// ==============================
	// Address decode
	// ==============================
	assign aw_idx = awaddr[MEM_IDX_W+1:2];
	assign ar_idx = araddr[MEM_IDX_W+1:2];
	// Any bit above the word index means past the end
	assign aw_in_range = (awaddr[ADDR_W-1:MEM_IDX_W+2] == '0);
	assign ar_in_range = (araddr[ADDR_W-1:MEM_IDX_W+2] == '0);

	// AW and W only taken as a pair
	assign awready = awvalid && wvalid && !bvalid && !init_active;
	assign wready  = awready;
	assign arready = arvalid && !rvalid && !init_active;

	assign wr_hs = awvalid && awready;
	assign rd_hs = arvalid && arready;

	// ==============================
	// Clear sequence
	// ==============================
	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			init_active <= 1'b1;
			init_cnt    <= '0;
		end
		else if (init_active)
		begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == MEM_IDX_W'(MEM_WORDS - 1))
				init_active <= 1'b0;    // Last word cleared
		end
	end

	// Array, one word per cycle during clear
	always_ff @(posedge CLK)
	begin
		if (init_active)
			mem[init_cnt] <= '0;
		else if (wr_hs && aw_in_range)
		begin
			for (int i = 0; i < STRB_W; i++)
			begin
				if (wstrb[i])
					mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// ==============================
	// Response channels
	// ==============================
	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (wr_hs)
			bresp <= aw_in_range ? RESP_OKAY : RESP_SLVERR;  // Dropped write
		if (rd_hs)
		begin
			rresp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
			rdata <= ar_in_range ? mem[ar_idx] : '0;
		end
	end

endmodule

//--- src/lsu_axi_master.sv
module lsu_axi_master (
	input  logic                       CLK,
	input  logic                       NRST,
	// Pipeline request
	input  logic                       load_req,
	input  logic                       store_req,
	input  logic [1:0]                 size,
	input  logic                       is_signed,
	input  logic [lsu_pkg::ADDR_W-1:0] addr,
	input  logic [lsu_pkg::DATA_W-1:0] wdata,
	// Status back to the pipeline
	output logic                       busy,
	output logic                       done,
	output logic                       err,
	output logic [lsu_pkg::DATA_W-1:0] rdata,
	// AXI write side
	output logic [lsu_pkg::ADDR_W-1:0] awaddr,
	output logic                       awvalid,
	input  logic                       awready,
	output logic [lsu_pkg::DATA_W-1:0] wdata_o,
	output logic [lsu_pkg::STRB_W-1:0] wstrb,
	output logic                       wvalid,
	input  logic                       wready,
	input  logic [1:0]                 bresp,
	input  logic                       bvalid,
	output logic                       bready,
	// AXI read side
	output logic [lsu_pkg::ADDR_W-1:0] araddr,
	output logic                       arvalid,
	input  logic                       arready,
	input  logic [lsu_pkg::DATA_W-1:0] rdata_i,
	input  logic [1:0]                 rresp,
	input  logic                       rvalid,
	output logic                       rready
);
	import lsu_pkg::*;

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_WADDR,    // AW and W outstanding
		S_WRESP,
		S_RADDR,
		S_RDATA,
		S_FINISH
	} state_t;

	state_t            state;
	logic              op_store_q;
	logic [1:0]        size_q;
	logic              signed_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic              aw_done_q;   // AW taken, W may still be open
	logic              w_done_q;
	logic              err_q;       // Slave answered non-OKAY
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] lane_data;
	logic [STRB_W-1:0] lane_strb;
	logic              misaligned;
	logic [DATA_W-1:0] load_result;
	logic              accept;
	logic              mis_done;    // Misaligned access finishing without bus traffic
	logic              aw_hs;
	logic              w_hs;

	lsu_lane_align u_lane_align (
		.size        (size_q),
		.is_signed   (signed_q),
		.addr_lsb    (addr_q[1:0]),
		.store_data  (wdata_q),
		.load_word   (rdata_i),
		.lane_data   (lane_data),
		.lane_strb   (lane_strb),
		.misaligned  (misaligned),
		.load_result (load_result)
	);

	// ==============================
	// Bus side
	// ==============================
	assign awaddr  = {addr_q[ADDR_W-1:2], 2'b00};  // Word address
	assign araddr  = {addr_q[ADDR_W-1:2], 2'b00};
	assign wdata_o = lane_data;
	assign wstrb   = lane_strb;
	assign awvalid = (state == S_WADDR) && !misaligned && !aw_done_q;
	assign wvalid  = (state == S_WADDR) && !misaligned && !w_done_q;
	assign bready  = (state == S_WRESP);
	assign arvalid = (state == S_RADDR) && !misaligned;
	assign rready  = (state == S_RDATA);

	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;

	// ==============================
	// Pipeline status
	// ==============================
	assign mis_done = ((state == S_WADDR) || (state == S_RADDR)) && misaligned;
	assign done     = (state == S_FINISH) || mis_done;
	assign busy     = (state != S_IDLE) && !done;
	assign err      = ((state == S_FINISH) && err_q) || mis_done;
	assign rdata    = (mis_done && !op_store_q) ? '0 : rdata_q;   // Failed load reads zero
	assign accept   = (load_req || store_req) && !busy;

	// Operand latch on accept
	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			op_store_q <= store_req;    // Store wins if both pulse
			size_q     <= size;
			signed_q   <= is_signed;
			addr_q     <= addr;
			wdata_q    <= wdata;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!NRST)
		begin
			state     <= S_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			err_q     <= 1'b0;
		end
		else if (accept)
		begin
			state     <= store_req ? S_WADDR : S_RADDR;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			err_q     <= 1'b0;
		end
		else
		begin
			case (state)
				S_WADDR:
				begin
					if (misaligned)
						state <= S_IDLE;
					else
					begin
						aw_done_q <= aw_done_q || aw_hs;
						w_done_q  <= w_done_q || w_hs;
						if ((aw_done_q || aw_hs) && (w_done_q || w_hs))
							state <= S_WRESP;
					end
				end
				S_WRESP:
				begin
					if (bvalid)
					begin
						err_q <= (bresp != RESP_OKAY);
						state <= S_FINISH;
					end
				end
				S_RADDR:
				begin
					if (misaligned)
						state <= S_IDLE;
					else if (arready)
						state <= S_RDATA;
				end
				S_RDATA:
				begin
					if (rvalid)
					begin
						err_q <= (rresp != RESP_OKAY);
						state <= S_FINISH;
					end
				end
				S_FINISH: state <= S_IDLE;    // done pulse lasts one cycle
				default:  state <= S_IDLE;
			endcase
		end
	end

	// Load result, held until the next load ends
	always_ff @(posedge CLK)
	begin
		if (mis_done && !op_store_q)
			rdata_q <= '0;
		else if ((state == S_RDATA) && rvalid)
			rdata_q <= (rresp == RESP_OKAY) ? load_result : '0;
	end

endmodule

//--- src/lsu_lane_align.sv
module lsu_lane_align (
	input  logic [1:0]                 size,
	input  logic                       is_signed,
	input  logic [1:0]                 addr_lsb,
	input  logic [lsu_pkg::DATA_W-1:0] store_data,
	input  logic [lsu_pkg::DATA_W-1:0] load_word,
	output logic [lsu_pkg::DATA_W-1:0] lane_data,
	output logic [lsu_pkg::STRB_W-1:0] lane_strb,
	output logic                       misaligned,
	output logic [lsu_pkg::DATA_W-1:0] load_result
);
	import lsu_pkg::*;

	logic [4:0]        shamt;       // Byte offset in bits
	logic [DATA_W-1:0] load_shift;  // Addressed field moved down to lane 0

	assign shamt = {addr_lsb, 3'b000};
	assign load_shift = load_word >> shamt;

	// ==============================
	// Store side
	// ==============================
	always_comb
	begin
		case (size)
			SIZE_BYTE:
			begin
				lane_data  = DATA_W'(store_data[7:0]) << shamt;
				lane_strb  = STRB_W'(1'b1) << addr_lsb;
				misaligned = 1'b0;              // Any offset is fine
			end
			SIZE_HALF:
			begin
				lane_data  = DATA_W'(store_data[15:0]) << shamt;
				lane_strb  = STRB_W'(2'b11) << addr_lsb;
				misaligned = addr_lsb[0];       // Odd offset
			end
			default:
			begin
				// Full word, lanes as given
				lane_data  = store_data;
				lane_strb  = '1;
				misaligned = (addr_lsb != 2'b00);
			end
		endcase
	end

	// ==============================
	// Load side
	// ==============================
	// Sign bit only copied upward for signed loads
	always_comb
	begin
		case (size)
			SIZE_BYTE:
				load_result = {{(DATA_W-8){load_shift[7] & is_signed}},
					load_shift[7:0]};
			SIZE_HALF:
				load_result = {{(DATA_W-16){load_shift[15] & is_signed}},
					load_shift[15:0]};
			default:
				load_result = load_shift;       // Offset is zero when aligned
		endcase
	end

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

	// ==============================
	// Bus geometry
	// ==============================
	localparam int ADDR_W = 32;                // AXI byte address
	localparam int DATA_W = 32;                // AXI data bus
	localparam int STRB_W = DATA_W / 8;        // One strobe per byte lane

	// ==============================
	// SRAM geometry
	// ==============================
	// 256 words, so byte addresses 0 to 1023
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);   // Word index bits

	// ==============================
	// Access size codes
	// ==============================
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;   // Code 3 is unused

	// ==============================
	// AXI response codes
	// ==============================
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
